// File: hw/sap_defines.svh
// Width and depth macros for the SAP-1 computer, included by the RTL and the testbench
`ifndef SAP_DEFINES_SVH
`define SAP_DEFINES_SVH

// Address space, also the PC width
`define SAP_ADDR_W 4

// Bus, register and RAM word width
`define SAP_DATA_W 8

// Microcode control word, one bit per signal
`define SAP_CTRL_W 15

// 16 bytes of RAM, the full address space
`define SAP_RAM_DEPTH 16

`endif

// File: hw/sap_isa_pkg.sv
// Opcode values and RAM word layout, imported by the controller, datapath and testbench
`default_nettype none

`include "sap_defines.svh"

package sap_isa_pkg;

  // Nibble positions inside the instr view
  localparam int NIB_OPC = 1;  // Upper nibble, opcode
  localparam int NIB_ARG = 0;  // Lower nibble, operand address

  // Opcodes, unused values run as no-ops
  localparam logic [`SAP_ADDR_W-1:0] OP_LDA = 4'd0;   // Load A from RAM
  localparam logic [`SAP_ADDR_W-1:0] OP_ADD = 4'd1;   // A = A + RAM
  localparam logic [`SAP_ADDR_W-1:0] OP_SUB = 4'd2;   // A = A - RAM
  localparam logic [`SAP_ADDR_W-1:0] OP_OUT = 4'd14;  // A to output register
  localparam logic [`SAP_ADDR_W-1:0] OP_HLT = 4'd15;  // Stop the clock of execution

  // One RAM byte, either an opcode/operand pair or plain data
  typedef union packed {
    logic [1:0][`SAP_ADDR_W-1:0] instr;  // [NIB_OPC] opcode, [NIB_ARG] operand
    logic [`SAP_DATA_W-1:0]      data;   // Raw byte
  } sap_word_u;

endpackage

`default_nettype wire

// File: hw/sap_ctrl_pkg.sv
// Control word bit map and stage numbers shared by the programmer, controller and datapath
`default_nettype none

`include "sap_defines.svh"

package sap_ctrl_pkg;

  // Control word bit positions, _N bits are active low
  localparam int SIG_PC_INC          = 14;  // PC count up
  localparam int SIG_PC_EN           = 13;  // PC onto bus
  localparam int SIG_PC_LOAD         = 12;  // PC from bus
  localparam int SIG_MAR_ADDR_LOAD_N = 11;  // MAR address from bus
  localparam int SIG_MAR_MEM_LOAD_N  = 10;  // MAR write-data from bus
  localparam int SIG_RAM_EN_N        = 9;   // RAM onto bus
  localparam int SIG_RAM_LOAD_N      = 8;   // RAM write at MAR address
  localparam int SIG_IR_LOAD_N       = 7;   // IR from bus
  localparam int SIG_IR_EN_N         = 6;   // IR operand onto bus
  localparam int SIG_REGA_LOAD_N     = 5;   // A from bus
  localparam int SIG_REGA_EN         = 4;   // A onto bus
  localparam int SIG_ADDER_SUB       = 3;   // Adder does A - B
  localparam int SIG_ADDER_EN        = 2;   // Adder onto bus
  localparam int SIG_REGB_LOAD_N     = 1;   // B from bus
  localparam int SIG_OUT_LOAD_N      = 0;   // Output register from bus

  // Nothing asserted, low-active bits parked high
  localparam logic [`SAP_CTRL_W-1:0] CTRL_IDLE = 15'b000_1111_1110_0011;

  // Micro-step counter
  localparam int STAGE_W = 3;
  localparam logic [STAGE_W-1:0] STAGE_T0   = 3'd0;
  localparam logic [STAGE_W-1:0] STAGE_T1   = 3'd1;
  localparam logic [STAGE_W-1:0] STAGE_T2   = 3'd2;
  localparam logic [STAGE_W-1:0] STAGE_T3   = 3'd3;
  localparam logic [STAGE_W-1:0] STAGE_T4   = 3'd4;
  localparam logic [STAGE_W-1:0] STAGE_T5   = 3'd5;
  localparam logic [STAGE_W-1:0] STAGE_HOLD = 3'd6;  // Parked, waiting for work

endpackage

`default_nettype wire

// File: hw/sap_programmer.sv
// RAM loader, writes one user byte per new_byte rising edge while programming is high
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_programmer (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [7:0]             ui_in,        // Byte to store
  input  logic                   programming,  // Level, selects loader mode
  input  logic                   new_byte,     // Rising edge starts a write
  output logic [`SAP_CTRL_W-1:0] prog_ctrl,
  output logic [`SAP_DATA_W-1:0] prog_bus
);
  import sap_ctrl_pkg::*;

  logic [STAGE_W-1:0]     stage;
  logic                   new_byte_d;  // Previous new_byte for edge detect
  logic                   byte_edge;
  logic                   pending;     // Edge seen, sequence not started yet
  logic [`SAP_DATA_W-1:0] byte_q;      // Captured ui_in
  logic [`SAP_ADDR_W-1:0] prog_addr;   // Next RAM address to fill

  assign byte_edge = new_byte & ~new_byte_d;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      new_byte_d <= 1'b0;
      pending    <= 1'b0;
    end else begin
      new_byte_d <= new_byte;
      if (!programming)
        pending <= 1'b0;              // Drop stale requests
      else if (byte_edge)
        pending <= 1'b1;
      else if (stage == STAGE_HOLD)
        pending <= 1'b0;              // Consumed as stage enters T0
    end
  end

  always_ff @(posedge clk) begin
    if (byte_edge)
      byte_q <= ui_in;
  end

  // HOLD -> T0..T5 -> HOLD, one pass per byte
  always_ff @(posedge clk) begin
    if (!resetn || !programming)
      stage <= STAGE_HOLD;
    else if (stage == STAGE_HOLD)
      stage <= pending ? STAGE_T0 : STAGE_HOLD;
    else if (stage == STAGE_T5)
      stage <= STAGE_HOLD;
    else
      stage <= stage + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn)
      prog_addr <= '0;
    else if (stage == STAGE_T1)
      prog_addr <= prog_addr + 1'b1;  // Address already latched in MAR at T0
  end

  // Stage decode, stays idle in HOLD
  always_comb begin
    prog_ctrl = CTRL_IDLE;
    prog_bus  = '0;
    case (stage)
      STAGE_T0: begin
        prog_bus                       = {{(`SAP_DATA_W-`SAP_ADDR_W){1'b0}}, prog_addr};
        prog_ctrl[SIG_MAR_ADDR_LOAD_N] = 1'b0;
      end
      STAGE_T4: begin
        prog_bus                      = byte_q;
        prog_ctrl[SIG_MAR_MEM_LOAD_N] = 1'b0;
      end
      STAGE_T5: prog_ctrl[SIG_RAM_LOAD_N] = 1'b0;  // Commit write data
      default: ;                                    // T1..T3 and HOLD idle
    endcase
  end

endmodule

`default_nettype wire

// File: hw/sap_controller.sv
// Microcode sequencer, steps T0..T5 per instruction and decodes IR into the control word
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_controller (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   programming,  // Loader owns the machine
  input  sap_isa_pkg::sap_word_u ir_value,     // Current instruction
  output logic [`SAP_CTRL_W-1:0] ctrl_word,
  output logic                   halted        // Sticky until reset
);
  import sap_ctrl_pkg::*;
  import sap_isa_pkg::*;

  logic [STAGE_W-1:0]     stage;
  logic [`SAP_ADDR_W-1:0] opcode;
  logic                   is_alu;  // ADD or SUB

  assign opcode = ir_value.instr[NIB_OPC];
  assign is_alu = (opcode == OP_ADD) || (opcode == OP_SUB);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stage  <= STAGE_HOLD;
      halted <= 1'b0;
    end else if (programming || halted) begin
      stage <= STAGE_HOLD;           // Frozen
    end else begin
      case (stage)
        STAGE_HOLD: stage <= STAGE_T0;
        STAGE_T3: begin
          if (opcode == OP_HLT) begin
            stage  <= STAGE_HOLD;
            halted <= 1'b1;
          end else begin
            stage <= STAGE_T4;
          end
        end
        STAGE_T5: stage <= STAGE_T0;  // Next fetch
        default:  stage <= stage + 1'b1;
      endcase
    end
  end

  // Fetch is common, execute depends on the opcode in IR
  always_comb begin
    ctrl_word = CTRL_IDLE;
    case (stage)
      STAGE_T0: begin
        ctrl_word[SIG_PC_EN]           = 1'b1;  // PC -> MAR
        ctrl_word[SIG_MAR_ADDR_LOAD_N] = 1'b0;
      end
      STAGE_T1: ctrl_word[SIG_PC_INC] = 1'b1;
      STAGE_T2: begin
        ctrl_word[SIG_RAM_EN_N]  = 1'b0;        // RAM -> IR
        ctrl_word[SIG_IR_LOAD_N] = 1'b0;
      end
      STAGE_T3: begin
        if (opcode == OP_LDA || is_alu) begin
          ctrl_word[SIG_IR_EN_N]         = 1'b0;  // Operand -> MAR
          ctrl_word[SIG_MAR_ADDR_LOAD_N] = 1'b0;
        end else if (opcode == OP_OUT) begin
          ctrl_word[SIG_REGA_EN]    = 1'b1;       // A -> output
          ctrl_word[SIG_OUT_LOAD_N] = 1'b0;
        end
      end
      STAGE_T4: begin
        if (opcode == OP_LDA) begin
          ctrl_word[SIG_RAM_EN_N]    = 1'b0;      // RAM -> A
          ctrl_word[SIG_REGA_LOAD_N] = 1'b0;
        end else if (is_alu) begin
          ctrl_word[SIG_RAM_EN_N]    = 1'b0;      // RAM -> B
          ctrl_word[SIG_REGB_LOAD_N] = 1'b0;
        end
      end
      STAGE_T5: begin
        if (is_alu) begin
          ctrl_word[SIG_ADDER_EN]    = 1'b1;      // Sum -> A
          ctrl_word[SIG_REGA_LOAD_N] = 1'b0;
          ctrl_word[SIG_ADDER_SUB]   = (opcode == OP_SUB);
        end
      end
      default: ;                                  // HOLD
    endcase
  end

endmodule

`default_nettype wire

// File: hw/sap_datapath.sv
// Registers, RAM, adder and bus multiplexer, driven by the loader or microcode control word
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_datapath (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   programming,  // Selects prog_ctrl and prog_bus
  input  logic [`SAP_CTRL_W-1:0] prog_ctrl,
  input  logic [`SAP_DATA_W-1:0] prog_bus,
  input  logic [`SAP_CTRL_W-1:0] ctrl_word,
  output sap_isa_pkg::sap_word_u ir_value,
  output logic [7:0]             out_value,
  output logic                   out_strobe    // One cycle after output load
);
  import sap_ctrl_pkg::*;
  import sap_isa_pkg::*;

  localparam int PAD_W = `SAP_DATA_W - `SAP_ADDR_W;

  logic [`SAP_CTRL_W-1:0] ctrl;    // Active control word
  logic [`SAP_DATA_W-1:0] bus;
  logic [`SAP_ADDR_W-1:0] pc;
  logic [`SAP_ADDR_W-1:0] mar;     // RAM address
  logic [`SAP_DATA_W-1:0] mdr;     // RAM write data, MAR memory-data half
  sap_word_u              ram [`SAP_RAM_DEPTH];
  sap_word_u              ir;
  logic [`SAP_DATA_W-1:0] reg_a;
  logic [`SAP_DATA_W-1:0] reg_b;
  logic [`SAP_DATA_W-1:0] sum;     // Wraps mod 256
  logic [`SAP_DATA_W-1:0] ram_rd;

  assign ctrl     = programming ? prog_ctrl : ctrl_word;
  assign ram_rd   = ram[mar].data;
  assign sum      = ctrl[SIG_ADDER_SUB] ? reg_a - reg_b : reg_a + reg_b;
  assign ir_value = ir;

  // Bus mux, one enabled source expected
  always_comb begin
    if (programming)
      bus = prog_bus;                           // Loader owns the bus
    else if (ctrl[SIG_PC_EN])
      bus = {{PAD_W{1'b0}}, pc};
    else if (!ctrl[SIG_RAM_EN_N])
      bus = ram_rd;
    else if (!ctrl[SIG_IR_EN_N])
      bus = {{PAD_W{1'b0}}, ir.instr[NIB_ARG]};
    else if (ctrl[SIG_REGA_EN])
      bus = reg_a;
    else if (ctrl[SIG_ADDER_EN])
      bus = sum;
    else
      bus = '0;                                 // Floating bus reads 0
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pc         <= '0;
      mar        <= '0;
      reg_a      <= '0;
      reg_b      <= '0;
      out_value  <= '0;
      out_strobe <= 1'b0;
    end else begin
      if (ctrl[SIG_PC_LOAD])
        pc <= bus[`SAP_ADDR_W-1:0];
      else if (ctrl[SIG_PC_INC])
        pc <= pc + 1'b1;
      if (!ctrl[SIG_MAR_ADDR_LOAD_N])
        mar <= bus[`SAP_ADDR_W-1:0];
      if (!ctrl[SIG_REGA_LOAD_N])
        reg_a <= bus;
      if (!ctrl[SIG_REGB_LOAD_N])
        reg_b <= bus;
      if (!ctrl[SIG_OUT_LOAD_N])
        out_value <= bus;
      out_strobe <= ~ctrl[SIG_OUT_LOAD_N];     // Follows the load by a cycle
    end
  end

  // Storage without reset
  always_ff @(posedge clk) begin
    if (!ctrl[SIG_MAR_MEM_LOAD_N])
      mdr <= bus;
    if (!ctrl[SIG_RAM_LOAD_N])
      ram[mar].data <= mdr;                     // Write at latched address
    if (!ctrl[SIG_IR_LOAD_N])
      ir.data <= bus;
  end

endmodule

`default_nettype wire

// File: hw/sap_computer.sv
// Top level of the SAP-1 computer, joins the RAM loader, microcode controller and datapath
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_computer (
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] ui_in,        // Program byte
  input  logic       programming,  // High while loading RAM
  input  logic       new_byte,     // Rising edge stores ui_in
  output logic [7:0] out_value,
  output logic       out_strobe,
  output logic       halted
);
  import sap_isa_pkg::*;

  logic [`SAP_CTRL_W-1:0] prog_ctrl;
  logic [`SAP_DATA_W-1:0] prog_bus;
  logic [`SAP_CTRL_W-1:0] ctrl_word;
  sap_word_u              ir_value;  // IR back to the decoder

  sap_programmer programmer_i (
    .clk, .resetn, .ui_in, .programming, .new_byte,
    .prog_ctrl, .prog_bus
  );

  sap_controller controller_i (
    .clk, .resetn, .programming, .ir_value,
    .ctrl_word, .halted
  );

  sap_datapath datapath_i (
    .clk, .resetn, .programming, .prog_ctrl, .prog_bus, .ctrl_word,
    .ir_value, .out_value, .out_strobe
  );

endmodule

`default_nettype wire

// File: sim/sap_computer_props.sv
// Bound assertions on the datapath control word and bus sources, attached to sap_datapath by bind
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_computer_props (
  input logic                   clk,
  input logic                   resetn,
  input logic                   programming,
  input logic [`SAP_CTRL_W-1:0] ctrl          // Active control word inside the datapath
);
  import sap_ctrl_pkg::*;

  logic       reset_d;  // Reset seen at the previous edge
  logic [4:0] src_en;   // Microcode bus drivers

  always_ff @(posedge clk) begin
    reset_d <= !resetn;
  end

  assign src_en = {ctrl[SIG_PC_EN], !ctrl[SIG_RAM_EN_N], !ctrl[SIG_IR_EN_N],
                   ctrl[SIG_REGA_EN], ctrl[SIG_ADDER_EN]};

  // Stage registers settle one edge into reset
  idle_in_reset: assert property (@(posedge clk) (!resetn && reset_d) |-> ctrl == CTRL_IDLE)
    else $error("control word not idle during reset");

  // Loader counts as a source while programming
  one_bus_source: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({programming, src_en}))
    else $error("more than one bus source enabled");

  no_write_running: assert property (@(posedge clk) disable iff (!resetn)
    !programming |-> ctrl[SIG_RAM_LOAD_N])
    else $error("RAM write asserted while programming is low");

endmodule

bind sap_datapath sap_computer_props props_i (.clk, .resetn, .programming, .ctrl);

`default_nettype wire

// File: sim/sap_computer_tb.sv
// Testbench for sap_computer, loads a table of programs and checks OUT values against a model
`timescale 1ns/100ps
`default_nettype none

`include "sap_defines.svh"

module sap_computer_tb;
  import sap_isa_pkg::*;

  localparam int N_PROGS = 5;
  localparam int MAX_OUTS = 4;

  // Fixed programs, random entries reuse codes 1 and 2 with new data
  localparam logic [7:0] FIXED_PROGS [3][16] = '{
    '{8'h0E, 8'hE0, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,   // LDA 14, OUT, HLT
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h5A, 8'h00},
    '{8'h0D, 8'h1E, 8'hE0, 8'h2F, 8'hE0, 8'hF0, 8'h00, 8'h00,   // LDA, ADD, OUT, SUB, OUT, HLT
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hF0, 8'h20, 8'h30},
    '{8'h0C, 8'hE0, 8'h1D, 8'hE0, 8'h1E, 8'hE0, 8'h2F, 8'hE0,   // Four OUTs
      8'hF0, 8'hE0, 8'h00, 8'h00, 8'h07, 8'h08, 8'h09, 8'h03}   // OUT after HLT never runs
  };

  logic       clk;
  logic       resetn;
  logic [7:0] ui_in;
  logic       programming;
  logic       new_byte;
  logic [7:0] out_value;
  logic       out_strobe;
  logic       halted;

  sap_word_u prog_tab [N_PROGS][`SAP_RAM_DEPTH];  // RAM image per entry
  sap_word_u exp_out  [N_PROGS][MAX_OUTS];         // Model results
  int        exp_cnt  [N_PROGS];
  int        n_checks = 0;
  int        n_errors = 0;

  sap_computer dut_i (
    .clk, .resetn, .ui_in, .programming, .new_byte,
    .out_value, .out_strobe, .halted
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Ends a hung run, budget per entry covers load plus execute
  initial begin
    repeat (N_PROGS * 400) @(posedge clk);
    $display("Watchdog expired after %0d cycles, DUT did not halt", N_PROGS * 400);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input sap_word_u got, input sap_word_u exp);
    n_checks++;
    if (got.data !== exp.data) begin
      n_errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got.data, exp.data);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;  // Drive and sample away from the edge
  endtask

  // Instruction-level model of the SAP-1 subset
  task automatic run_reference(input int p);
    logic [3:0] pc;
    logic [7:0] acc;
    logic [3:0] opc;
    logic [3:0] arg;
    logic       done;
    pc         = '0;
    acc        = '0;
    done       = 1'b0;
    exp_cnt[p] = 0;
    for (int s = 0; s < 64 && !done; s++) begin
      opc = prog_tab[p][pc].data[7:4];
      arg = prog_tab[p][pc].data[3:0];
      pc  = pc + 4'd1;
      case (opc)
        OP_LDA: acc = prog_tab[p][arg].data;
        OP_ADD: acc = acc + prog_tab[p][arg].data;  // Wraps mod 256
        OP_SUB: acc = acc - prog_tab[p][arg].data;
        OP_OUT: begin
          if (exp_cnt[p] < MAX_OUTS)
            exp_out[p][exp_cnt[p]] = acc;
          exp_cnt[p]++;
        end
        OP_HLT: done = 1'b1;
        default: ;                                   // No-op
      endcase
    end
  endtask

  task automatic build_table();
    logic [31:0] rng;
    rng = 32'd89;
    for (int p = 0; p < N_PROGS; p++)
      for (int a = 0; a < `SAP_RAM_DEPTH; a++)
        prog_tab[p][a].data = FIXED_PROGS[(p < 3) ? p : p - 2][a];
    for (int a = 13; a < 16; a++) begin  // Data of the ADD/SUB program
      rng = xorshift32(rng);
      prog_tab[3][a].data = rng[7:0];
    end
    for (int a = 12; a < 16; a++) begin  // Data of the four-OUT program
      rng = xorshift32(rng);
      prog_tab[4][a].data = rng[7:0];
    end
    for (int p = 0; p < N_PROGS; p++)
      run_reference(p);
  endtask

  task automatic apply_reset();
    resetn      = 1'b0;
    programming = 1'b0;
    new_byte    = 1'b0;
    ui_in       = '0;
    repeat (8) step();
    check_flag("out_strobe", out_strobe, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_word("out_value", out_value, 8'h00);
    resetn      = 1'b1;
    programming = 1'b1;  // Keeps the controller parked
  endtask

  task automatic load_program(input int p);
    for (int a = 0; a < `SAP_RAM_DEPTH; a++) begin
      ui_in    = prog_tab[p][a].data;
      new_byte = 1'b1;
      step();
      new_byte = 1'b0;
      repeat (11) step();  // Write done 7 cycles after the edge
    end
    programming = 1'b0;
  endtask

  task automatic run_entry(input int p);
    int n_seen;
    n_seen = 0;
    apply_reset();
    load_program(p);
    while (!halted) begin
      step();
      if (out_strobe) begin
        if (n_seen < exp_cnt[p] && n_seen < MAX_OUTS)
          check_word("out_value", out_value, exp_out[p][n_seen]);
        n_seen++;
      end
    end
    repeat (12) begin     // Halt must stick with no more output
      step();
      check_flag("out_strobe", out_strobe, 1'b0);
    end
    check_flag("halted", halted, 1'b1);
    if (n_seen != exp_cnt[p]) begin
      n_errors++;
      $display("Program %0d gave %0d output strobes, model expects %0d", p, n_seen, exp_cnt[p]);
    end
  endtask

  initial begin
    resetn      = 1'b0;
    ui_in       = '0;
    programming = 1'b0;
    new_byte    = 1'b0;
    build_table();
    for (int p = 0; p < N_PROGS; p++)
      run_entry(p);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/sap_isa_pkg.sv
hw/sap_ctrl_pkg.sv
hw/sap_programmer.sv
hw/sap_controller.sv
hw/sap_datapath.sv
hw/sap_computer.sv
sim/sap_computer_props.sv
sim/sap_computer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SAP-1 testbench with Verilator, pass is decided from sim.log
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module sap_computer_tb -f list.f -o sim_top

./obj_dir/sim_top | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi
